// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_noc_axi_rx
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_EXE = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	-./$(SIM_EXE) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
source/noc_flit_pkg.sv
source/noc_reg_pkg.sv
source/noc_flit_fifo.sv
source/noc_write_read_demux.sv
source/noc_vc_arbiter.sv
source/noc_demux_regs.sv
source/noc_axi_rx_top.sv
verif/noc_demux_chk.sv
verif/tb_noc_axi_rx.sv

// File: source/noc_axi_rx_top.sv
`timescale 1ns/1ps

module noc_axi_rx_top
  import noc_flit_pkg::*, noc_reg_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  noc_flit_t           flit_in,
  input  logic [VC_COUNT-1:0] flit_in_valid,
  output logic [VC_COUNT-1:0] flit_in_ready,
  output noc_flit_t           wr_flit,
  output logic                wr_valid,
  input  logic                wr_ready,
  output noc_flit_t           rd_flit,
  output logic                rd_valid,
  input  logic                rd_ready,
  input  apb_req_t            apb_req,
  output apb_rsp_t            apb_rsp
);

  noc_flit_t           fifo_flit [VC_COUNT];
  logic [VC_COUNT-1:0] fifo_valid;
  logic [VC_COUNT-1:0] fifo_ready;
  noc_flit_t           dmx_wr_flit [VC_COUNT];
  noc_flit_t           dmx_rd_flit [VC_COUNT];
  logic [VC_COUNT-1:0] dmx_wr_valid;
  logic [VC_COUNT-1:0] dmx_rd_valid;
  logic [VC_COUNT-1:0] dmx_wr_ready;
  logic [VC_COUNT-1:0] dmx_rd_ready;
  demux_cfg_t          demux_cfg;
  logic                drop_pulse;

  // One input FIFO per virtual channel
  for (genvar i = 0; i < VC_COUNT; i++) begin : g_fifo
    noc_flit_fifo u_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_flit   (flit_in),
      .in_valid  (flit_in_valid[i]),
      .in_ready  (flit_in_ready[i]),
      .out_flit  (fifo_flit[i]),
      .out_valid (fifo_valid[i]),
      .out_ready (fifo_ready[i])
    );
  end

  noc_write_read_demux u_demux (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg        (demux_cfg),
    .fifo_flit  (fifo_flit),
    .fifo_valid (fifo_valid),
    .fifo_ready (fifo_ready),
    .wr_flit    (dmx_wr_flit),
    .rd_flit    (dmx_rd_flit),
    .wr_valid   (dmx_wr_valid),
    .rd_valid   (dmx_rd_valid),
    .wr_ready   (dmx_wr_ready),
    .rd_ready   (dmx_rd_ready),
    .drop_pulse (drop_pulse)
  );

  noc_vc_arbiter u_wr_arb (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_flit   (dmx_wr_flit),
    .in_valid  (dmx_wr_valid),
    .in_ready  (dmx_wr_ready),
    .out_flit  (wr_flit),
    .out_valid (wr_valid),
    .out_ready (wr_ready)
  );

  noc_vc_arbiter u_rd_arb (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_flit   (dmx_rd_flit),
    .in_valid  (dmx_rd_valid),
    .in_ready  (dmx_rd_ready),
    .out_flit  (rd_flit),
    .out_valid (rd_valid),
    .out_ready (rd_ready)
  );

  noc_demux_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .cfg        (demux_cfg),
    .drop_pulse (drop_pulse)
  );

endmodule

// File: source/noc_demux_regs.sv
`timescale 1ns/1ps

module noc_demux_regs
  import noc_flit_pkg::*, noc_reg_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  apb_req_t   apb_req,
  output apb_rsp_t   apb_rsp,
  output demux_cfg_t cfg,
  input  logic       drop_pulse
);

  demux_cfg_t                cfg_q;
  logic [DROP_CNT_WIDTH-1:0] drop_cnt;
  logic                      access;
  logic                      wr_en;
  logic                      hit_type_sel;
  logic                      hit_drop_cnt;
  logic [APB_DATA_WIDTH-1:0] type_sel_word;

  assign access       = apb_req.psel && apb_req.penable;
  assign wr_en        = access && apb_req.pwrite;
  assign hit_type_sel = (apb_req.paddr == REG_TYPE_SEL_ADDR);
  assign hit_drop_cnt = (apb_req.paddr == REG_DROP_CNT_ADDR);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q <= TYPE_SEL_RESET;
    end else if (wr_en && hit_type_sel) begin
      cfg_q.write_type <= noc_pkt_type_e'(apb_req.pwdata[TYPE_SEL_WR_LSB +: PKT_TYPE_WIDTH]);
      cfg_q.read_type  <= noc_pkt_type_e'(apb_req.pwdata[TYPE_SEL_RD_LSB +: PKT_TYPE_WIDTH]);
    end
  end

  // Clear on any write; otherwise count up and stick at max
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      drop_cnt <= '0;
    end else if (wr_en && hit_drop_cnt) begin
      drop_cnt <= '0;
    end else if (drop_pulse && (drop_cnt != '1)) begin
      drop_cnt <= drop_cnt + 1'b1;
    end
  end

  always_comb begin
    type_sel_word = '0;
    type_sel_word[TYPE_SEL_WR_LSB +: PKT_TYPE_WIDTH] = cfg_q.write_type;
    type_sel_word[TYPE_SEL_RD_LSB +: PKT_TYPE_WIDTH] = cfg_q.read_type;
  end

  always_comb begin
    apb_rsp.pready  = 1'b1;   // No wait states
    apb_rsp.pslverr = access && !(hit_type_sel || hit_drop_cnt);
    apb_rsp.prdata  = '0;
    if (access && !apb_req.pwrite) begin
      if (hit_type_sel) begin
        apb_rsp.prdata = type_sel_word;
      end else if (hit_drop_cnt) begin
        apb_rsp.prdata = APB_DATA_WIDTH'(drop_cnt);
      end
    end
  end

  assign cfg = cfg_q;

endmodule

// File: source/noc_flit_fifo.sv
`timescale 1ns/1ps

module noc_flit_fifo
  import noc_flit_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  noc_flit_t in_flit,
  input  logic      in_valid,
  output logic      in_ready,
  output noc_flit_t out_flit,
  output logic      out_valid,
  input  logic      out_ready
);

  localparam logic [FIFO_PTR_WIDTH-1:0] LAST_PTR = FIFO_PTR_WIDTH'(FIFO_DEPTH - 1);
  localparam logic [FIFO_CNT_WIDTH-1:0] FULL_CNT = FIFO_CNT_WIDTH'(FIFO_DEPTH);

  noc_flit_t                 mem [FIFO_DEPTH];
  logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
  logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
  logic [FIFO_CNT_WIDTH-1:0] count;
  logic                      push;
  logic                      pop;

  assign in_ready  = (count != FULL_CNT);
  assign out_valid = (count != '0);
  assign out_flit  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // Flit storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_flit;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      // Occupancy only moves when exactly one side fires
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: source/noc_flit_pkg.sv
package noc_flit_pkg;

  // Network sizes
  localparam int VC_COUNT       = 2;
  localparam int VC_IDX_WIDTH   = $clog2(VC_COUNT);
  localparam int FIFO_DEPTH     = 4;
  localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);
  localparam int DATA_WIDTH     = 32;
  localparam int PKT_TYPE_WIDTH = 2;

  // Packet type codes carried on the head flit
  typedef enum logic [PKT_TYPE_WIDTH-1:0] {
    NOC_READ         = 2'd0,
    NOC_NP_WRITE     = 2'd1,
    NOC_POSTED_WRITE = 2'd2,
    NOC_RESPONSE     = 2'd3
  } noc_pkt_type_e;

  // One 37-bit flit on the link
  typedef struct packed {
    logic                  head;
    logic                  tail;
    logic                  vc;
    noc_pkt_type_e         pkt_type;   // Only valid on the head flit
    logic [DATA_WIDTH-1:0] data;
  } noc_flit_t;

  // Per-channel routing state in the demux
  typedef enum logic [1:0] {
    ROUTE_NONE  = 2'd0,
    ROUTE_WRITE = 2'd1,
    ROUTE_READ  = 2'd2,
    ROUTE_DROP  = 2'd3
  } noc_route_e;

endpackage

// File: source/noc_reg_pkg.sv
package noc_reg_pkg;

  import noc_flit_pkg::*;

  localparam int APB_ADDR_WIDTH = 8;
  localparam int APB_DATA_WIDTH = 32;
  localparam int DROP_CNT_WIDTH = 16;

  typedef struct packed {
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
  } apb_rsp_t;

  // Register map
  localparam logic [APB_ADDR_WIDTH-1:0] REG_TYPE_SEL_ADDR = 8'h00;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_DROP_CNT_ADDR = 8'h04;

  // Field positions inside the type select register
  localparam int TYPE_SEL_WR_LSB = 0;
  localparam int TYPE_SEL_RD_LSB = 4;

  typedef struct packed {
    noc_pkt_type_e write_type;
    noc_pkt_type_e read_type;
  } demux_cfg_t;

  localparam demux_cfg_t TYPE_SEL_RESET = '{write_type: NOC_NP_WRITE, read_type: NOC_READ};

endpackage

// File: source/noc_vc_arbiter.sv
`timescale 1ns/1ps

module noc_vc_arbiter
  import noc_flit_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  noc_flit_t           in_flit [VC_COUNT],
  input  logic [VC_COUNT-1:0] in_valid,
  output logic [VC_COUNT-1:0] in_ready,
  output noc_flit_t           out_flit,
  output logic                out_valid,
  input  logic                out_ready
);

  logic                    locked;    // Packet in progress or offered
  logic [VC_IDX_WIDTH-1:0] lock_ch;
  logic [VC_IDX_WIDTH-1:0] last_ch;   // Round-robin pointer
  logic [VC_IDX_WIDTH-1:0] rr_pick;
  logic                    rr_found;
  logic [VC_IDX_WIDTH-1:0] gnt;

  // Search starts one past the last granted channel
  always_comb begin
    logic [VC_IDX_WIDTH-1:0] idx;
    rr_found = 1'b0;
    rr_pick  = last_ch;
    for (int k = 1; k <= VC_COUNT; k++) begin
      idx = VC_IDX_WIDTH'((int'(last_ch) + k) % VC_COUNT);
      if (!rr_found && in_valid[idx]) begin
        rr_found = 1'b1;
        rr_pick  = idx;
      end
    end
  end

  assign gnt       = locked ? lock_ch : rr_pick;
  assign out_valid = locked ? in_valid[lock_ch] : rr_found;
  assign out_flit  = in_flit[gnt];

  for (genvar i = 0; i < VC_COUNT; i++) begin : g_ready
    assign in_ready[i] = out_ready && (gnt == VC_IDX_WIDTH'(i));
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      locked  <= 1'b0;
      lock_ch <= '0;
      last_ch <= '0;
    end else if (out_valid) begin
      // Hold the grant from the first offer until the tail is taken
      if (out_ready && out_flit.tail) begin
        locked <= 1'b0;
      end else begin
        locked  <= 1'b1;
        lock_ch <= gnt;
      end
      if (out_ready && out_flit.head) begin
        last_ch <= gnt;
      end
    end
  end

endmodule

// File: source/noc_write_read_demux.sv
`timescale 1ns/1ps

module noc_write_read_demux
  import noc_flit_pkg::*, noc_reg_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  demux_cfg_t          cfg,
  input  noc_flit_t           fifo_flit [VC_COUNT],
  input  logic [VC_COUNT-1:0] fifo_valid,
  output logic [VC_COUNT-1:0] fifo_ready,
  output noc_flit_t           wr_flit [VC_COUNT],
  output noc_flit_t           rd_flit [VC_COUNT],
  output logic [VC_COUNT-1:0] wr_valid,
  output logic [VC_COUNT-1:0] rd_valid,
  input  logic [VC_COUNT-1:0] wr_ready,
  input  logic [VC_COUNT-1:0] rd_ready,
  output logic                drop_pulse
);

  logic [VC_COUNT-1:0] drop_hit;

  for (genvar i = 0; i < VC_COUNT; i++) begin : g_chan
    noc_route_e route_q;    // Route of the packet in flight
    noc_route_e route_sel;  // Decoded from the current head flit
    noc_route_e route;
    logic       head_valid;
    logic       busy;

    assign head_valid = fifo_valid[i] && fifo_flit[i].head;
    assign busy       = (route_q != ROUTE_NONE);

    always_comb begin
      if (fifo_flit[i].pkt_type == cfg.write_type) begin
        route_sel = ROUTE_WRITE;
      end else if (fifo_flit[i].pkt_type == cfg.read_type) begin
        route_sel = ROUTE_READ;
      end else begin
        route_sel = ROUTE_DROP;
      end
    end

    // A stalled head keeps the route it was first shown with
    assign route = busy ? route_q : (head_valid ? route_sel : ROUTE_NONE);

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        route_q <= ROUTE_NONE;
      end else if (fifo_valid[i]) begin
        if (fifo_ready[i] && fifo_flit[i].tail) begin
          route_q <= ROUTE_NONE;
        end else if (!busy) begin
          route_q <= route;
        end
      end
    end

    assign wr_flit[i]  = fifo_flit[i];
    assign rd_flit[i]  = fifo_flit[i];
    assign wr_valid[i] = fifo_valid[i] && (route == ROUTE_WRITE);
    assign rd_valid[i] = fifo_valid[i] && (route == ROUTE_READ);

    // Drop route and stray body flits drain one per cycle
    always_comb begin
      case (route)
        ROUTE_WRITE: fifo_ready[i] = wr_ready[i];
        ROUTE_READ:  fifo_ready[i] = rd_ready[i];
        default:     fifo_ready[i] = 1'b1;
      endcase
    end

    assign drop_hit[i] = head_valid && (route == ROUTE_DROP);
  end

  assign drop_pulse = |drop_hit;

endmodule

// File: verif/noc_demux_chk.sv
`timescale 1ns/1ps

module noc_demux_chk
  import noc_flit_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input noc_flit_t wr_flit,
  input logic      wr_valid,
  input logic      wr_ready,
  input noc_flit_t rd_flit,
  input logic      rd_valid,
  input logic      rd_ready
);

  logic wr_open;  // Head taken and tail still to come
  logic wr_vc;
  logic rd_open;
  logic rd_vc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_open <= 1'b0;
      wr_vc   <= 1'b0;
      rd_open <= 1'b0;
      rd_vc   <= 1'b0;
    end else begin
      if (wr_valid && wr_ready) begin
        wr_open <= !wr_flit.tail;
        if (wr_flit.head) begin
          wr_vc <= wr_flit.vc;
        end
      end
      if (rd_valid && rd_ready) begin
        rd_open <= !rd_flit.tail;
        if (rd_flit.head) begin
          rd_vc <= rd_flit.vc;
        end
      end
    end
  end

  a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !wr_valid && !rd_valid)
    else $error("Output valid high while in reset");

  a_wr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    wr_valid && !wr_ready |=> wr_valid && $stable(wr_flit))
    else $error("Write output changed while stalled");

  a_rd_stable: assert property (@(posedge clk) disable iff (!rst_n)
    rd_valid && !rd_ready |=> rd_valid && $stable(rd_flit))
    else $error("Read output changed while stalled");

  a_wr_one_channel: assert property (@(posedge clk) disable iff (!rst_n)
    wr_valid && wr_open |-> wr_flit.vc == wr_vc)
    else $error("Write output switched channel inside a packet");

  a_rd_one_channel: assert property (@(posedge clk) disable iff (!rst_n)
    rd_valid && rd_open |-> rd_flit.vc == rd_vc)
    else $error("Read output switched channel inside a packet");

endmodule

// File: verif/tb_noc_axi_rx.sv
`timescale 1ns/1ps

module tb_noc_axi_rx
  import noc_flit_pkg::*, noc_reg_pkg::*;
();

  localparam int DRIVE_DELAY = 10;
  // Packet flits of all tests summed (40 + 24 + 14 + 12 + 18)
  localparam int TOTAL_FLITS     = 108;
  localparam int WATCHDOG_CYCLES = TOTAL_FLITS * 20 + 2000;
  localparam int DRAIN_LIMIT     = 1000;
  localparam int APB_WAIT_LIMIT  = 16;

  logic                clk;
  logic                rst_n;
  noc_flit_t           flit_in;
  logic [VC_COUNT-1:0] flit_in_valid;
  logic [VC_COUNT-1:0] flit_in_ready;
  noc_flit_t           wr_flit;
  logic                wr_valid;
  logic                wr_ready;
  noc_flit_t           rd_flit;
  logic                rd_valid;
  logic                rd_ready;
  apb_req_t            apb_req;
  apb_rsp_t            apb_rsp;

  noc_flit_t tx_q [VC_COUNT][$];       // Flits waiting to enter each channel
  noc_flit_t exp_wr_q [VC_COUNT][$];
  noc_flit_t exp_rd_q [VC_COUNT][$];
  logic      out_open [2] = '{1'b0, 1'b0};  // One entry per output with write first
  logic      out_vc [2] = '{1'b0, 1'b0};
  demux_cfg_t  model_cfg;
  logic [31:0] rng;
  int          exp_drops;
  int          flit_errors = 0;
  int          reg_errors;
  int          misc_errors;
  string       cur_test = "reset";

  noc_axi_rx_top i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .flit_in       (flit_in),
    .flit_in_valid (flit_in_valid),
    .flit_in_ready (flit_in_ready),
    .wr_flit       (wr_flit),
    .wr_valid      (wr_valid),
    .wr_ready      (wr_ready),
    .rd_flit       (rd_flit),
    .rd_valid      (rd_valid),
    .rd_ready      (rd_ready),
    .apb_req       (apb_req),
    .apb_rsp       (apb_rsp)
  );

  bind noc_axi_rx_top noc_demux_chk i_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_flit  (wr_flit),
    .wr_valid (wr_valid),
    .wr_ready (wr_ready),
    .rd_flit  (rd_flit),
    .rd_valid (rd_valid),
    .rd_ready (rd_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Field layout of the type select register
  function automatic logic [31:0] pack_type_sel(input demux_cfg_t c);
    return {26'd0, c.read_type, 2'b00, c.write_type};
  endfunction

  function automatic noc_route_e expected_route(input noc_pkt_type_e t);
    if (t == model_cfg.write_type) begin
      return ROUTE_WRITE;
    end else if (t == model_cfg.read_type) begin
      return ROUTE_READ;
    end
    return ROUTE_DROP;
  endfunction

  function automatic int inputs_left();
    int n;
    n = 0;
    for (int k = 0; k < VC_COUNT; k++) begin
      n += tx_q[VC_IDX_WIDTH'(k)].size();
    end
    return n;
  endfunction

  function automatic int outputs_left(input logic reads_only);
    int n;
    n = 0;
    for (int k = 0; k < VC_COUNT; k++) begin
      n += exp_rd_q[VC_IDX_WIDTH'(k)].size();
      if (!reads_only) begin
        n += exp_wr_q[VC_IDX_WIDTH'(k)].size();
      end
    end
    return n;
  endfunction

  task automatic compare_flit(input string what, input noc_flit_t exp, input noc_flit_t act);
    if (act !== exp) begin
      flit_errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic compare_reg(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      reg_errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic compare_slverr(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      reg_errors++;
      $display("CHECK FAILED %s %s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  // Queue a packet and book its flits against the output it must reach
  task automatic send_packet(input logic [VC_IDX_WIDTH-1:0] ch, input noc_pkt_type_e t,
                             input int len);
    noc_flit_t  f;
    noc_route_e r;
    r = expected_route(t);
    for (int i = 0; i < len; i++) begin
      rng        = xorshift32(rng);
      f.head     = (i == 0);
      f.tail     = (i == len - 1);
      f.vc       = ch;
      f.pkt_type = t;
      f.data     = rng;
      tx_q[ch].push_back(f);
      if (r == ROUTE_WRITE) begin
        exp_wr_q[ch].push_back(f);
      end else if (r == ROUTE_READ) begin
        exp_rd_q[ch].push_back(f);
      end
    end
    if (r == ROUTE_DROP) begin
      exp_drops++;
    end
  endtask

  task automatic wait_drain(input string what, input logic reads_only);
    int cycles;
    int pending;
    cycles  = 0;
    pending = outputs_left(reads_only) + (reads_only ? 0 : inputs_left());
    while (pending > 0 && cycles < DRAIN_LIMIT) begin
      @(posedge clk);
      #DRIVE_DELAY;
      cycles++;
      pending = outputs_left(reads_only) + (reads_only ? 0 : inputs_left());
    end
    if (pending > 0) begin
      misc_errors++;
      $display("%s: %s timed out, %0d flits never accepted and %0d flits never arrived",
               cur_test, what, inputs_left(), outputs_left(reads_only));
      for (int k = 0; k < VC_COUNT; k++) begin
        tx_q[VC_IDX_WIDTH'(k)].delete();
        exp_wr_q[VC_IDX_WIDTH'(k)].delete();
        exp_rd_q[VC_IDX_WIDTH'(k)].delete();
      end
    end
  endtask

  task automatic apb_access(input logic [APB_ADDR_WIDTH-1:0] addr, input logic write,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic slverr);
    int waits;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #DRIVE_DELAY;
    apb_req.penable = 1'b1;
    waits = 0;
    @(negedge clk);
    while (!apb_rsp.pready && waits < APB_WAIT_LIMIT) begin
      @(negedge clk);
      waits++;
    end
    if (!apb_rsp.pready) begin
      misc_errors++;
      $display("%s: APB access to %h never completed, pready stayed low", cur_test, addr);
    end
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(posedge clk);
    #DRIVE_DELAY;
    apb_req = '0;
  endtask

  task automatic apb_write(input logic [APB_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                           output logic slverr);
    logic [31:0] unused;
    apb_access(addr, 1'b1, data, unused, slverr);
  endtask

  task automatic apb_read(input logic [APB_ADDR_WIDTH-1:0] addr, output logic [31:0] data,
                          output logic slverr);
    apb_access(addr, 1'b0, 32'd0, data, slverr);
  endtask

  task automatic program_types(input noc_pkt_type_e wr_t, input noc_pkt_type_e rd_t);
    logic slverr;
    model_cfg.write_type = wr_t;
    model_cfg.read_type  = rd_t;
    apb_write(REG_TYPE_SEL_ADDR, pack_type_sel(model_cfg), slverr);
    compare_slverr("type select write", 1'b0, slverr);
  endtask

  task automatic check_drop_count(input string what);
    logic [31:0] rdata;
    logic        slverr;
    apb_read(REG_DROP_CNT_ADDR, rdata, slverr);
    compare_reg(what, 32'(exp_drops), rdata);
    compare_slverr(what, 1'b0, slverr);
  endtask

  task automatic clear_drop_count();
    logic slverr;
    apb_write(REG_DROP_CNT_ADDR, 32'h0000_5a5a, slverr);  // Any value clears
    compare_slverr("drop count clear", 1'b0, slverr);
    exp_drops = 0;
    check_drop_count("drop count after clear");
  endtask

  task automatic test_registers();
    logic [31:0] rdata;
    logic        slverr;
    cur_test = "registers";
    apb_read(REG_TYPE_SEL_ADDR, rdata, slverr);
    compare_reg("type select after reset", pack_type_sel(TYPE_SEL_RESET), rdata);
    compare_slverr("type select read", 1'b0, slverr);
    check_drop_count("drop count after reset");
    // Bits outside the two fields are written high and must read back as zero
    model_cfg = '{write_type: NOC_RESPONSE, read_type: NOC_POSTED_WRITE};
    apb_write(REG_TYPE_SEL_ADDR, pack_type_sel(model_cfg) | 32'hffff_ffcc, slverr);
    compare_slverr("type select write", 1'b0, slverr);
    apb_read(REG_TYPE_SEL_ADDR, rdata, slverr);
    compare_reg("type select readback", pack_type_sel(model_cfg), rdata);
    program_types(NOC_NP_WRITE, NOC_READ);
    apb_read(8'h08, rdata, slverr);
    compare_slverr("unmapped read", 1'b1, slverr);
    compare_reg("unmapped read data", 32'd0, rdata);
    apb_write(8'h0c, 32'hffff_ffff, slverr);
    compare_slverr("unmapped write", 1'b1, slverr);
    apb_read(REG_TYPE_SEL_ADDR, rdata, slverr);
    compare_reg("type select after unmapped write", pack_type_sel(model_cfg), rdata);
  endtask

  task automatic test_basic_routing();
    cur_test = "basic_routing";
    for (int i = 0; i < 8; i++) begin
      send_packet(VC_IDX_WIDTH'(i % 2), NOC_NP_WRITE, (i % 4) + 1);
      send_packet(VC_IDX_WIDTH'(i % 2), NOC_READ, ((i + 1) % 4) + 1);
    end
    wait_drain("routing", 1'b0);
  endtask

  task automatic test_back_pressure();
    int cycles;
    cur_test = "back_pressure";
    wr_ready = 1'b0;
    for (int i = 0; i < 4; i++) begin
      send_packet(1'b0, NOC_NP_WRITE, 3);
    end
    for (int i = 0; i < 6; i++) begin
      send_packet(1'b1, NOC_READ, 2);
    end
    wait_drain("reads beside stalled writes", 1'b1);
    // Release the write output in short bursts
    cycles = 0;
    while (exp_wr_q[0].size() > 0 && cycles < DRAIN_LIMIT) begin
      wr_ready = ((cycles / 3) % 2) == 0;
      @(posedge clk);
      #DRIVE_DELAY;
      cycles++;
    end
    wr_ready = 1'b1;
    wait_drain("writes after release", 1'b0);
  endtask

  task automatic test_drops();
    cur_test  = "drops";
    exp_drops = 0;
    for (int i = 0; i < 3; i++) begin
      send_packet(VC_IDX_WIDTH'(i % 2), NOC_POSTED_WRITE, 2);
      send_packet(VC_IDX_WIDTH'((i + 1) % 2), NOC_RESPONSE, 2);
    end
    // A read behind the drops on each channel shows both channels have drained
    send_packet(1'b0, NOC_READ, 1);
    send_packet(1'b1, NOC_READ, 1);
    wait_drain("dropped traffic", 1'b0);
    check_drop_count("drop count");
    clear_drop_count();
  endtask

  task automatic test_reprogram();
    cur_test = "reprogram";
    program_types(NOC_POSTED_WRITE, NOC_READ);
    send_packet(1'b0, NOC_POSTED_WRITE, 2);
    send_packet(1'b1, NOC_NP_WRITE, 3);
    send_packet(1'b1, NOC_POSTED_WRITE, 2);
    send_packet(1'b0, NOC_NP_WRITE, 3);
    send_packet(1'b0, NOC_READ, 1);
    send_packet(1'b1, NOC_READ, 1);
    wait_drain("reprogrammed traffic", 1'b0);
    check_drop_count("non-posted drops");
    program_types(NOC_NP_WRITE, NOC_READ);
    clear_drop_count();
  endtask

  task automatic test_interleave();
    int cycles;
    cur_test = "interleave";
    send_packet(1'b0, NOC_NP_WRITE, 4);
    send_packet(1'b1, NOC_READ, 4);
    send_packet(1'b0, NOC_READ, 3);
    send_packet(1'b1, NOC_NP_WRITE, 3);
    send_packet(1'b0, NOC_NP_WRITE, 2);
    send_packet(1'b1, NOC_READ, 2);
    // Read output stalls every third cycle while packets are in flight
    cycles = 0;
    while (outputs_left(1'b1) > 0 && cycles < DRAIN_LIMIT) begin
      rd_ready = (cycles % 3) != 1;
      @(posedge clk);
      #DRIVE_DELAY;
      cycles++;
    end
    rd_ready = 1'b1;
    wait_drain("interleaved traffic", 1'b0);
  endtask

  // Flit driver round-robins over channels whose FIFO has room
  initial begin
    logic [VC_IDX_WIDTH-1:0] rr_next;
    logic [VC_IDX_WIDTH-1:0] c;
    logic                    found;
    flit_in       = '0;
    flit_in_valid = '0;
    rr_next       = '0;
    wait (rst_n === 1'b1);
    forever begin
      @(posedge clk);
      #DRIVE_DELAY;
      flit_in_valid = '0;
      found         = 1'b0;
      for (int k = 0; k < VC_COUNT; k++) begin
        c = VC_IDX_WIDTH'((int'(rr_next) + k) % VC_COUNT);
        if (!found && tx_q[c].size() > 0 && flit_in_ready[c]) begin
          found            = 1'b1;
          flit_in          = tx_q[c].pop_front();
          flit_in_valid[c] = 1'b1;
          rr_next          = VC_IDX_WIDTH'((int'(c) + 1) % VC_COUNT);
        end
      end
    end
  end

  task automatic check_output(input logic port, input noc_flit_t f);
    noc_flit_t e;
    logic      have;
    string     name;
    name = port ? "read" : "write";
    have = 1'b0;
    if (out_open[port] && (f.vc !== out_vc[port])) begin
      flit_errors++;
      $display("%s: %s output switched channel inside a packet", cur_test, name);
    end
    out_open[port] = !f.tail;
    if (f.head) begin
      out_vc[port] = f.vc;
    end
    if (!port && exp_wr_q[f.vc].size() > 0) begin
      e    = exp_wr_q[f.vc].pop_front();
      have = 1'b1;
    end else if (port && exp_rd_q[f.vc].size() > 0) begin
      e    = exp_rd_q[f.vc].pop_front();
      have = 1'b1;
    end
    if (have) begin
      compare_flit({name, " flit"}, e, f);
    end else begin
      flit_errors++;
      $display("%s: unexpected flit %h on %s output", cur_test, f, name);
    end
  endtask

  // Handshakes seen mid-cycle complete at the next rising edge
  always @(negedge clk) begin
    if (rst_n === 1'b1) begin
      if (wr_valid && wr_ready) begin
        check_output(1'b0, wr_flit);
      end
      if (rd_valid && rd_ready) begin
        check_output(1'b1, rd_flit);
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    rng         = 32'd21828;
    exp_drops   = 0;
    reg_errors  = 0;
    misc_errors = 0;
    model_cfg   = TYPE_SEL_RESET;
    rst_n       = 1'b0;
    wr_ready    = 1'b1;
    rd_ready    = 1'b1;
    apb_req     = '0;
    repeat (8) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    test_registers();
    test_basic_routing();
    test_back_pressure();
    test_drops();
    test_reprogram();
    test_interleave();
    $display("Errors: %0d flit, %0d register, %0d other", flit_errors, reg_errors, misc_errors);
    if (flit_errors + reg_errors + misc_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
